// ==== Makefile ====
# Verilator simulation of the MMIO slave testbench

VERILATOR ?= verilator
TOP       ?= tb_mmio_top
FILELIST  ?= mmio_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== mmio_top.f ====
verilog/mmio_pkg.sv
verilog/mmio_decode.sv
verilog/afu_descriptor.sv
verilog/mmio_regs.sv
verilog/algo_engine.sv
verilog/mmio_top.sv
verification/mmio_checker.sv
verification/tb_mmio_top.sv

// ==== verification/mmio_checker.sv ====
// Response checker: expected-ack queue, comparisons, per-test and total result lines
`default_nettype none
`timescale 1ns/10ps

module mmio_checker (
  input wire                       clock,
  input wire                       rstn,
  input wire mmio_pkg::mmio_resp_t mmio_resp,
  input wire [0:1]                 mmio_errors
);

  import mmio_pkg::*;

  int          cycle = 0;
  int          due_q[$];
  logic [0:63] data_q[$];
  logic [0:1]  err_q[$];

  int          test_count = 0;
  int          test_checks = 0;
  int          test_errors = 0;
  int          total_checks = 0;
  int          total_errors = 0;

  logic [0:63] exp_data;
  logic [0:1]  exp_err;
  logic        exp_parity;

  task automatic expect_resp(input int due, input logic [0:63] data, input logic [0:1] err);
    due_q.push_back(due);
    data_q.push_back(data);
    err_q.push_back(err);
  endtask

  function automatic int outstanding();
    return due_q.size();
  endfunction

  function automatic int error_total();
    return total_errors;
  endfunction

  task automatic report_mismatch(input string name, input logic [0:63] expected,
                                 input logic [0:63] actual);
    $display("Fail at %0t: %s expected %h got %h", $time, name, expected, actual);
    test_errors++;
  endtask

  task automatic report_problem(input string text);
    $display("Error at %0t: %s", $time, text);
    test_errors++;
  endtask

  task automatic end_test(input string name);
    $display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
    test_count++;
    total_checks += test_checks;
    total_errors += test_errors;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic report_totals();
    $display("totals: %0d tests, %0d checks, %0d errors", test_count, total_checks, total_errors);
  endtask

  always @(posedge clock) begin
    cycle <= cycle + 1;
  end

  ////////////////////////////////////////////////////////////
  // Compare at the falling edge, where outputs are settled
  ////////////////////////////////////////////////////////////

  always @(negedge clock) begin
    if (rstn) begin
      // Parity errors pulse one cycle ahead of the ack
      exp_err = 2'b00;
      foreach (due_q[i]) begin
        if (due_q[i] == cycle + 1) begin
          exp_err = err_q[i];
        end
      end
      test_checks++;
      if (mmio_errors !== exp_err) begin
        report_mismatch("mmio_errors", {62'h0, exp_err}, {62'h0, mmio_errors});
      end

      while (due_q.size() != 0 && due_q[0] < cycle) begin
        report_problem($sformatf("no ack for the command due in cycle %0d", due_q[0]));
        void'(due_q.pop_front());
        void'(data_q.pop_front());
        void'(err_q.pop_front());
      end

      if (mmio_resp.ack === 1'b1) begin
        if (due_q.size() == 0 || due_q[0] != cycle) begin
          report_problem($sformatf("ack in cycle %0d with no command due", cycle));
        end else begin
          exp_data   = data_q[0];
          exp_parity = ($countones(exp_data) % 2) == 0;
          test_checks++;
          if (mmio_resp.data !== exp_data) begin
            report_mismatch("mmio_resp.data", exp_data, mmio_resp.data);
          end
          if (mmio_resp.data_parity !== exp_parity) begin
            report_mismatch("mmio_resp.data_parity", {63'h0, exp_parity},
                            {63'h0, mmio_resp.data_parity});
          end
          void'(due_q.pop_front());
          void'(data_q.pop_front());
          void'(err_q.pop_front());
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/tb_mmio_top.sv ====
// Testbench top: clock, reset, xorshift stimulus, reference model and timeout
`default_nettype none
`timescale 1ns/10ps

module tb_mmio_top;

  import mmio_pkg::*;

  localparam int RESET_CYCLES = 4;

  // Cycle budget of each test, in issued commands
  localparam int DESC_LEN    = 40;
  localparam int MIXED_LEN   = 60;
  localparam int PARITY_LEN  = 26;
  localparam int ENGINE_LEN  = 6 * 42;
  localparam int ABORT_LEN   = 70;
  localparam int DRAIN_LEN   = 10;
  localparam int MARGIN      = 100;
  localparam int CYCLE_LIMIT = RESET_CYCLES + DESC_LEN + MIXED_LEN + PARITY_LEN
                               + ENGINE_LEN + ABORT_LEN + 5 * DRAIN_LEN + MARGIN;

  logic        clock;
  logic        rstn;
  mmio_req_t   mmio_req;
  mmio_resp_t  mmio_resp;
  logic [0:1]  mmio_errors;
  int          cycle = 0;
  logic [31:0] rng;

  // Reference model, kept at two edges ahead of the issue cycle
  algo_state_e m_state;
  logic [0:15] m_done;
  logic [0:15] m_remaining;
  logic [0:2]  m_sticky;
  int          model_edge;

  // Events per future edge, indexed by edge modulo 16
  logic        ev_cmd   [0:15];
  logic [0:3]  ev_op    [0:15];
  logic [0:15] ev_len   [0:15];
  logic        ev_clear [0:15];
  logic [0:2]  ev_set   [0:15];

  mmio_top mmio_top_inst (
    .clock       (clock),
    .rstn        (rstn),
    .mmio_req    (mmio_req),
    .mmio_resp   (mmio_resp),
    .mmio_errors (mmio_errors)
  );

  mmio_checker checker_inst (
    .clock       (clock),
    .rstn        (rstn),
    .mmio_resp   (mmio_resp),
    .mmio_errors (mmio_errors)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle <= cycle + 1;
  end

  initial begin
    wait (cycle >= CYCLE_LIMIT);
    $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("TB FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic random_word(output logic [31:0] value);
    rng   = xorshift32(rng);
    value = rng;
  endtask

  function automatic logic make_parity(input logic [0:63] value);
    return ($countones(value) % 2) == 0;
  endfunction

  function automatic logic [0:63] desc_word(input logic [0:23] addr, input logic dw);
    logic [0:63] entry;
    entry = 64'h0;
    if (addr[0:19] == 20'h0) begin
      entry = AFU_DESC_TABLE[addr[20:22]];
    end
    if (dw) begin
      return entry;
    end
    return addr[23] ? {entry[32:63], entry[32:63]} : {entry[0:31], entry[0:31]};
  endfunction

  function automatic logic [0:23] unmapped(input logic [0:23] a);
    if (a == ALGO_REQUEST || a == ALGO_STATUS || a == ERROR_REG) begin
      return a ^ 24'h80_0000;
    end
    return a;
  endfunction

  function automatic logic [0:63] request_word(input logic [0:3] op, input logic [0:15] len);
    return {op, 44'h0, len};
  endfunction

  // One clock edge of the engine and the sticky error bits
  task automatic step_model(input int e);
    int          slot;
    algo_state_e old_state;
    logic [0:15] old_done;
    slot      = e % 16;
    old_state = m_state;
    old_done  = m_done;
    m_sticky  = (ev_clear[slot] ? 3'b000 : m_sticky) | ev_set[slot];
    if (old_state == st_run) begin
      m_remaining = m_remaining - 16'd1;
      if (m_remaining == 16'd0) begin
        m_state = st_done;
        m_done  = old_done + 16'd1;
      end
    end
    if (ev_cmd[slot]) begin
      if (ev_op[slot] == op_start && old_state != st_run) begin
        if (ev_len[slot] == 16'd0) begin
          m_state = st_done;
          m_done  = old_done + 16'd1;
        end else begin
          m_state     = st_run;
          m_remaining = ev_len[slot];
        end
      end else if (ev_op[slot] == op_abort) begin
        m_state     = st_idle;
        m_remaining = 16'd0;
        m_done      = old_done;
      end else if (ev_op[slot] != op_nop && ev_op[slot] != op_start) begin
        // illegal_op lands in the sticky register one edge later
        ev_set[(e + 1) % 16] = ev_set[(e + 1) % 16] | 3'b100;
      end
    end
    ev_cmd[slot]   = 1'b0;
    ev_clear[slot] = 1'b0;
    ev_set[slot]   = 3'b000;
  endtask

  task automatic advance_model(input int k);
    while (model_edge < k + 2) begin
      model_edge = model_edge + 1;
      step_model(model_edge);
    end
  endtask

  task automatic idle_cycle();
    @(negedge clock);
    advance_model(cycle);
    mmio_req = '0;
  endtask

  // Issue one command and queue its expected response
  task automatic send(input logic cfg, input logic read, input logic dw,
                      input logic [0:23] addr, input logic [0:63] data,
                      input logic bad_addr, input logic bad_data);
    int          k;
    logic [0:63] exp_data;
    logic [0:1]  exp_err;
    @(negedge clock);
    k = cycle;
    advance_model(k);
    exp_data = 64'h0;
    exp_err  = {bad_data && !read, bad_addr};
    if (cfg && read) begin
      exp_data = desc_word(addr, dw);
    end else if (read && addr == ALGO_STATUS) begin
      exp_data = {m_state, m_done, m_remaining, 30'h0};
    end else if (read && addr == ERROR_REG) begin
      exp_data = {61'h0, m_sticky};
      ev_clear[(k + 3) % 16] = 1'b1;
    end else if (!cfg && !read && addr == ALGO_REQUEST) begin
      ev_cmd[(k + 4) % 16] = 1'b1;
      ev_op[(k + 4) % 16]  = data[0:3];
      ev_len[(k + 4) % 16] = data[48:63];
    end
    ev_set[(k + 3) % 16] = ev_set[(k + 3) % 16] | {1'b0, exp_err};
    checker_inst.expect_resp(k + MMIO_LATENCY, exp_data, exp_err);
    mmio_req = '{valid: 1'b1, cfg: cfg, read: read, doubleword: dw, address: addr,
                 address_parity: make_parity({40'h0, addr}) ^ bad_addr,
                 data: data, data_parity: make_parity(data) ^ bad_data};
  endtask

  // Idle until every queued response is seen, plus one quiet cycle
  task automatic drain();
    do begin
      idle_cycle();
      @(posedge clock);
    end while (checker_inst.outstanding() != 0);
    idle_cycle();
    @(posedge clock);
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic test_descriptor();
    logic [31:0] r;
    repeat (DESC_LEN) begin
      random_word(r);
      // About half inside the table
      send(1'b1, 1'b1, r[30], r[31] ? {20'h0, r[3:0]} : r[23:0], 64'h0, 1'b0, 1'b0);
    end
    drain();
    checker_inst.end_test("descriptor reads");
  endtask

  task automatic test_mixed();
    logic [31:0] r;
    logic [31:0] d;
    logic [31:0] e;
    repeat (MIXED_LEN) begin
      random_word(r);
      random_word(d);
      random_word(e);
      case (r[2:0])
        3'd0: send(1'b1, 1'b1, r[8], {20'h0, r[7:4]}, {d, e}, 1'b0, 1'b0);
        3'd1: send(1'b1, 1'b0, r[8], r[31:8], {d, e}, 1'b0, 1'b0);
        3'd2: send(1'b0, 1'b1, 1'b1, ALGO_STATUS, {d, e}, 1'b0, 1'b0);
        3'd3: send(1'b0, 1'b1, 1'b1, ERROR_REG, {d, e}, 1'b0, 1'b0);
        3'd4: send(1'b0, 1'b1, r[8], unmapped(r[31:8]), {d, e}, 1'b0, 1'b0);
        3'd5: send(1'b0, 1'b0, r[8], unmapped(r[31:8]), {d, e}, 1'b0, 1'b0);
        3'd6: send(1'b0, 1'b0, 1'b1, ALGO_REQUEST, request_word(op_nop, d[15:0]), 1'b0, 1'b0);
        default: send(1'b1, 1'b1, r[8], r[31:8], {d, e}, 1'b0, 1'b0);
      endcase
    end
    drain();
    checker_inst.end_test("ack timing and parity");
  endtask

  task automatic test_parity();
    logic [31:0] r;
    logic [31:0] d;
    logic [31:0] e;
    repeat (PARITY_LEN - 2) begin
      random_word(r);
      random_word(d);
      random_word(e);
      send(r[1], r[0], r[8], r[1] ? {20'h0, r[7:4]} : unmapped(r[31:8]), {d, e}, r[2], r[3]);
    end
    drain();
    // The second read must find the register cleared
    send(1'b0, 1'b1, 1'b1, ERROR_REG, 64'h0, 1'b0, 1'b0);
    send(1'b0, 1'b1, 1'b1, ERROR_REG, 64'h0, 1'b0, 1'b0);
    drain();
    checker_inst.end_test("parity errors");
  endtask

  task automatic test_engine();
    logic [31:0] r;
    logic [0:15] target;
    logic [0:15] job_len;
    logic        finished;
    int          polls;
    for (int job = 0; job < 6; job++) begin
      random_word(r);
      target = m_done + 16'd1;
      // Job 0 has no length, job 1 runs long enough to see a second start
      if (job == 0) begin
        job_len = 16'd0;
      end else if (job == 1) begin
        job_len = 16'd12;
      end else begin
        job_len = {12'h0, r[3:0]};
      end
      send(1'b0, 1'b0, 1'b1, ALGO_REQUEST, request_word(op_start, job_len), 1'b0, 1'b0);
      finished = 1'b0;
      polls    = 0;
      while (!finished && polls < 40) begin
        send(1'b0, 1'b1, 1'b1, ALGO_STATUS, 64'h0, 1'b0, 1'b0);
        polls++;
        // Start during a run, still running when it arrives
        if (polls == 3 && m_state == st_run && m_remaining > 16'd4) begin
          send(1'b0, 1'b0, 1'b1, ALGO_REQUEST, request_word(op_start, 16'd9), 1'b0, 1'b0);
        end
        finished = (m_state == st_done) && (m_done == target);
      end
    end
    drain();
    checker_inst.end_test("engine jobs");
  endtask

  task automatic test_abort();
    logic [31:0] r;
    logic [31:0] d;
    send(1'b0, 1'b0, 1'b1, ALGO_REQUEST, request_word(op_start, 16'd30), 1'b0, 1'b0);
    repeat (5) send(1'b0, 1'b1, 1'b1, ALGO_STATUS, 64'h0, 1'b0, 1'b0);
    send(1'b0, 1'b0, 1'b1, ALGO_REQUEST, request_word(op_abort, 16'd0), 1'b0, 1'b0);
    repeat (8) send(1'b0, 1'b1, 1'b1, ALGO_STATUS, 64'h0, 1'b0, 1'b0);
    random_word(r);
    send(1'b0, 1'b0, 1'b1, ALGO_REQUEST, request_word({1'b1, r[2:0]}, 16'd3), 1'b0, 1'b0);
    drain();
    send(1'b0, 1'b1, 1'b1, ERROR_REG, 64'h0, 1'b0, 1'b0);
    send(1'b0, 1'b1, 1'b1, ERROR_REG, 64'h0, 1'b0, 1'b0);
    repeat (16) begin
      random_word(r);
      random_word(d);
      send(1'b0, 1'b0, r[0], unmapped(r[31:8]), {d, r}, 1'b0, 1'b0);
      send(1'b0, 1'b1, r[1], unmapped(d[31:8]), 64'h0, 1'b0, 1'b0);
    end
    send(1'b0, 1'b1, 1'b1, ALGO_STATUS, 64'h0, 1'b0, 1'b0);
    send(1'b0, 1'b1, 1'b1, ERROR_REG, 64'h0, 1'b0, 1'b0);
    drain();
    checker_inst.end_test("abort, illegal opcode, unmapped");
  endtask

  initial begin
    rng         = 32'd94689;
    m_state     = st_idle;
    m_done      = 16'd0;
    m_remaining = 16'd0;
    m_sticky    = 3'b000;
    model_edge  = 0;
    for (int i = 0; i < 16; i++) begin
      ev_cmd[i]   = 1'b0;
      ev_op[i]    = 4'h0;
      ev_len[i]   = 16'd0;
      ev_clear[i] = 1'b0;
      ev_set[i]   = 3'b000;
    end
    mmio_req = '0;
    rstn     = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    rstn = 1'b1;

    test_descriptor();
    test_mixed();
    test_parity();
    test_engine();
    test_abort();

    checker_inst.report_totals();
    if (checker_inst.error_total() == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/afu_descriptor.sv ====
// AFU descriptor read port with single-word selection
`default_nettype none
`timescale 1ns/10ps

module afu_descriptor (
  input  wire                       clock,
  input  wire                       rstn,
  input  wire mmio_pkg::mmio_access_t access,
  output logic [0:63]               cfg_data
);

  import mmio_pkg::*;

  logic [0:63] entry;
  logic [0:63] selected;

  // Only the low doubleword offsets hit the table
  always_comb begin
    entry = '0;
    if (access.address[0:19] == 20'h0) begin
      entry = AFU_DESC_TABLE[access.address[20:22]];
    end
  end

  // Single-word reads return the chosen half twice
  always_comb begin
    if (access.doubleword) begin
      selected = entry;
    end else if (access.address[23]) begin
      selected = {entry[32:63], entry[32:63]};
    end else begin
      selected = {entry[0:31], entry[0:31]};
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      cfg_data <= '0;
    end else if (access.cfg_read) begin
      cfg_data <= selected;
    end else begin
      // Zero when idle so the response can OR sources together
      cfg_data <= '0;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/algo_engine.sv ====
// Algorithm engine FSM with job counter and status word
`default_nettype none
`timescale 1ns/10ps

module algo_engine (
  input  wire                    clock,
  input  wire                    rstn,
  input  wire mmio_pkg::algo_op_e  algo_op,
  input  wire [0:15]             algo_length,
  input  wire                    algo_cmd_valid,
  output mmio_pkg::algo_status_t algo_status,
  output logic                   illegal_op
);

  import mmio_pkg::*;

  algo_state_e state;
  logic [0:15] remaining;
  logic [0:15] done_count;

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      state      <= st_idle;
      remaining  <= '0;
      done_count <= '0;
      illegal_op <= 1'b0;
    end else begin
      illegal_op <= 1'b0;

      // Job countdown
      if (state == st_run) begin
        remaining <= remaining - 16'd1;
        if (remaining == 16'd1) begin
          state      <= st_done;
          done_count <= done_count + 16'd1;
        end
      end

      // Commands override the countdown
      if (algo_cmd_valid) begin
        case (algo_op)
          op_start: begin
            // Ignored while a job runs
            if (state != st_run) begin
              if (algo_length == 16'd0) begin
                state      <= st_done;
                done_count <= done_count + 16'd1;
              end else begin
                state     <= st_run;
                remaining <= algo_length;
              end
            end
          end
          op_abort: begin
            state      <= st_idle;
            remaining  <= '0;
            done_count <= done_count;
          end
          op_nop: begin
          end
          default: illegal_op <= 1'b1;
        endcase
      end
    end
  end

  assign algo_status = '{state: state, done_count: done_count, remaining: remaining,
                         reserved: '0};

  assert property (@(posedge clock) disable iff (!rstn)
    state inside {st_idle, st_run, st_done});

  // A running job always has cycles left
  assert property (@(posedge clock) disable iff (!rstn)
    (state == st_run) |-> (remaining != 16'd0));

endmodule

`default_nettype wire

// ==== verilog/mmio_decode.sv ====
// Host command register, parity check and access decode
`default_nettype none
`timescale 1ns/10ps

module mmio_decode (
  input  wire                    clock,
  input  wire                    rstn,
  input  wire mmio_pkg::mmio_req_t mmio_req,
  output mmio_pkg::mmio_access_t access,
  output logic [0:1]             parity_err
);

  import mmio_pkg::*;

  // First stage, the raw host command
  logic      req_valid;
  mmio_req_t req_q;

  logic addr_bad;
  logic data_bad;

  // Second stage, decoded flags and payload
  logic        cfg_read_q;
  logic        mmio_read_q;
  logic        mmio_write_q;
  logic        any_q;
  logic        doubleword_q;
  logic [0:23] address_q;
  logic [0:63] data_q;

  ////////////////////////////////////////////////////////////
  // Input register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      req_valid <= 1'b0;
    end else begin
      req_valid <= mmio_req.valid;
    end
  end

  always_ff @(posedge clock) begin
    req_q <= mmio_req;
  end

  ////////////////////////////////////////////////////////////
  // Parity check and decode
  ////////////////////////////////////////////////////////////

  assign addr_bad = odd_parity_bit({40'h0, req_q.address}) != req_q.address_parity;

  // Data parity only means something on writes
  assign data_bad = !req_q.read && (odd_parity_bit(req_q.data) != req_q.data_parity);

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      cfg_read_q   <= 1'b0;
      mmio_read_q  <= 1'b0;
      mmio_write_q <= 1'b0;
      any_q        <= 1'b0;
      parity_err   <= 2'b00;
    end else begin
      cfg_read_q   <= req_valid && req_q.cfg && req_q.read;
      mmio_read_q  <= req_valid && !req_q.cfg && req_q.read;
      mmio_write_q <= req_valid && !req_q.cfg && !req_q.read;
      // Config writes still need their ack
      any_q        <= req_valid;
      // A bad access is forwarded anyway, only flagged
      parity_err   <= req_valid ? {data_bad, addr_bad} : 2'b00;
    end
  end

  always_ff @(posedge clock) begin
    doubleword_q <= req_q.doubleword;
    address_q    <= req_q.address;
    data_q       <= req_q.data;
  end

  assign access = '{
    cfg_read:   cfg_read_q,
    mmio_read:  mmio_read_q,
    mmio_write: mmio_write_q,
    any:        any_q,
    doubleword: doubleword_q,
    address:    address_q,
    data:       data_q
  };

  // At most one access kind per cycle
  assert property (@(posedge clock) disable iff (!rstn)
    $onehot0({access.cfg_read, access.mmio_read, access.mmio_write}));

endmodule

`default_nettype wire

// ==== verilog/mmio_pkg.sv ====
// MMIO command and response structs, engine enums, register map, AFU descriptor, parity
`default_nettype none

package mmio_pkg;

  ////////////////////////////////////////////////////////////
  // Host command and response
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic        valid;
    logic        cfg;
    logic        read;
    logic        doubleword;
    logic [0:23] address;
    logic        address_parity;
    logic [0:63] data;
    logic        data_parity;
  } mmio_req_t;

  typedef struct packed {
    logic        ack;
    logic [0:63] data;
    logic        data_parity;
  } mmio_resp_t;

  // Decoded access, one stage after the host command
  typedef struct packed {
    logic        cfg_read;
    logic        mmio_read;
    logic        mmio_write;
    logic        any;
    logic        doubleword;
    logic [0:23] address;
    logic [0:63] data;
  } mmio_access_t;

  ////////////////////////////////////////////////////////////
  // Engine
  ////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    op_nop   = 4'h0,
    op_start = 4'h1,
    op_abort = 4'h2
  } algo_op_e;

  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_run  = 2'd1,
    st_done = 2'd2
  } algo_state_e;

  typedef struct packed {
    algo_state_e state;
    logic [0:15] done_count;
    logic [0:15] remaining;
    logic [0:29] reserved;
  } algo_status_t;

  // MMIO register map, word addresses
  localparam logic [0:23] ALGO_REQUEST = 24'h00_0020;
  localparam logic [0:23] ALGO_STATUS  = 24'h00_0022;
  localparam logic [0:23] ERROR_REG    = 24'h00_0024;

  localparam int MMIO_LATENCY = 4;

  // AFU descriptor, one doubleword per entry
  localparam int DESC_WORDS = 8;

  localparam logic [0:63] AFU_DESC_TABLE [0:DESC_WORDS-1] = '{
    64'h0000_0001_0001_8010,  // ints/process, processes, CR count, dedicated model
    64'h0000_0000_0000_0000,
    64'h0000_0000_0000_0001,  // config record length
    64'h0000_0000_0000_0100,  // config record offset
    64'h0000_0000_0000_0000,
    64'h0000_0000_0000_0000,
    64'h0000_0000_0000_0000,
    64'h0000_0000_0000_0000
  };

  // Zero extension keeps parity, so the 24-bit address goes through here too
  function automatic logic odd_parity_bit(input logic [0:63] value);
    return ~(^value);
  endfunction

endpackage

`default_nettype wire

// ==== verilog/mmio_regs.sv ====
// MMIO request, status and sticky error registers with response generation
`default_nettype none
`timescale 1ns/10ps

module mmio_regs (
  input  wire                       clock,
  input  wire                       rstn,
  input  wire mmio_pkg::mmio_access_t access,
  input  wire [0:63]                cfg_data,
  input  wire [0:1]                 parity_err,
  input  wire mmio_pkg::algo_status_t algo_status,
  input  wire                       illegal_op,
  output mmio_pkg::algo_op_e        algo_op,
  output logic [0:15]               algo_length,
  output logic                      algo_cmd_valid,
  output mmio_pkg::mmio_resp_t      mmio_resp,
  output logic [0:1]                mmio_errors
);

  import mmio_pkg::*;

  logic request_hit;
  logic error_read;

  // Sticky bits 61..63 of the error register
  logic [0:2]  sticky;
  logic [0:63] mmio_data;
  logic        ack_pending;
  logic [0:63] read_data;

  logic        resp_ack;
  logic [0:63] resp_data;
  logic        resp_parity;

  assign request_hit = access.mmio_write && (access.address == ALGO_REQUEST);
  assign error_read  = access.mmio_read && (access.address == ERROR_REG);

  ////////////////////////////////////////////////////////////
  // Engine command
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      algo_cmd_valid <= 1'b0;
    end else begin
      algo_cmd_valid <= request_hit;
    end
  end

  always_ff @(posedge clock) begin
    if (request_hit) begin
      algo_op     <= algo_op_e'(access.data[0:3]);
      algo_length <= access.data[48:63];
    end
  end

  ////////////////////////////////////////////////////////////
  // Errors and read data
  ////////////////////////////////////////////////////////////

  // Clear on read, but events landing on the same edge survive
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      sticky      <= 3'b000;
      mmio_errors <= 2'b00;
    end else begin
      sticky      <= (error_read ? 3'b000 : sticky) | {illegal_op, parity_err};
      mmio_errors <= parity_err;
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      mmio_data   <= '0;
      ack_pending <= 1'b0;
    end else begin
      ack_pending <= access.any;
      mmio_data   <= '0;
      if (access.mmio_read) begin
        case (access.address)
          ALGO_STATUS: mmio_data <= algo_status;
          ERROR_REG:   mmio_data <= {61'h0, sticky};
          default:     mmio_data <= '0;
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Response
  ////////////////////////////////////////////////////////////

  // Idle sources are zero, so OR is the merge
  assign read_data = cfg_data | mmio_data;

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      resp_ack <= 1'b0;
    end else begin
      resp_ack <= ack_pending;
    end
  end

  always_ff @(posedge clock) begin
    resp_data   <= read_data;
    resp_parity <= odd_parity_bit(read_data);
  end

  assign mmio_resp = '{ack: resp_ack, data: resp_data, data_parity: resp_parity};

  // Descriptor and register data never drive the merge together
  assert property (@(posedge clock) disable iff (!rstn)
    (cfg_data == '0) || (mmio_data == '0));

endmodule

`default_nettype wire

// ==== verilog/mmio_top.sv ====
// MMIO slave top level: decode, descriptor, registers and engine
`default_nettype none
`timescale 1ns/10ps

module mmio_top (
  input  wire                    clock,
  input  wire                    rstn,
  input  wire mmio_pkg::mmio_req_t mmio_req,
  output mmio_pkg::mmio_resp_t   mmio_resp,
  output logic [0:1]             mmio_errors
);

  import mmio_pkg::*;

  mmio_access_t access;
  logic [0:1]   parity_err;
  logic [0:63]  cfg_data;

  // Register block to engine
  algo_op_e     algo_op;
  logic [0:15]  algo_length;
  logic         algo_cmd_valid;
  algo_status_t algo_status;
  logic         illegal_op;

  mmio_decode mmio_decode_inst (
    .clock      (clock),
    .rstn       (rstn),
    .mmio_req   (mmio_req),
    .access     (access),
    .parity_err (parity_err)
  );

  afu_descriptor afu_descriptor_inst (
    .clock    (clock),
    .rstn     (rstn),
    .access   (access),
    .cfg_data (cfg_data)
  );

  mmio_regs mmio_regs_inst (
    .clock          (clock),
    .rstn           (rstn),
    .access         (access),
    .cfg_data       (cfg_data),
    .parity_err     (parity_err),
    .algo_status    (algo_status),
    .illegal_op     (illegal_op),
    .algo_op        (algo_op),
    .algo_length    (algo_length),
    .algo_cmd_valid (algo_cmd_valid),
    .mmio_resp      (mmio_resp),
    .mmio_errors    (mmio_errors)
  );

  algo_engine algo_engine_inst (
    .clock          (clock),
    .rstn           (rstn),
    .algo_op        (algo_op),
    .algo_length    (algo_length),
    .algo_cmd_valid (algo_cmd_valid),
    .algo_status    (algo_status),
    .illegal_op     (illegal_op)
  );

endmodule

`default_nettype wire
